// File: verification/pcs_loop_cases.txt
# opcode  blocks  header  lock
# header 1 is data 01, 2 is control 10, 0 or 3 invalid, 4 random data or control
# lock is the expected o_block_lock once the last block of the case has drained
# STALL holds i_enable low for the given number of cycles
SCRAMBLE 40 4 0
BYPASS 6 1 0
SCRAMBLE 20 4 1
TAG 4 2 1
IDLE 10 2 1
CORRUPT 8 0 1
SCRAMBLE 16 4 1
STALL 10 4 1
SCRAMBLE 23 1 1
CORRUPT 8 3 1
CORRUPT 16 0 0
SCRAMBLE 10 4 0

// File: sim.f
+incdir+verilog
verilog/pcs_pkg.sv
verilog/pcs_scrambler.sv
verilog/pcs_descrambler.sv
verilog/pcs_block_lock.sv
verilog/pcs_scrambler_loop.sv
verification/pcs_loop_tb.sv

// File: Bender.yml
package:
  name: pcs_scrambler_loop

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/pcs_pkg.sv
      - verilog/pcs_scrambler.sv
      - verilog/pcs_descrambler.sv
      - verilog/pcs_block_lock.sv
      - verilog/pcs_scrambler_loop.sv
      - target: simulation
        files:
          - verification/pcs_loop_tb.sv

// File: verification/pcs_loop_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcs_cfg.svh"

module pcs_loop_tb;

	import pcs_pkg::*;

	localparam int NB_PAYLOAD = `PCS_NB_CODED - `PCS_NB_SH;
	localparam int RESET_CYCLES = 16;
	localparam int MARGIN_CYCLES = 50;
	// x^39 term counted in line bits back
	localparam int TAP_AGE = 39;

	logic i_clock;
	logic i_reset;
	logic i_enable;
	logic i_valid;
	logic i_bypass;
	logic i_aligner_tag;
	logic i_idle_pattern_mode;
	logic [`PCS_NB_CODED-1:0] i_data;
	logic [`PCS_NB_TAGGED-1:0] o_tx_data;
	logic [`PCS_NB_CODED-1:0] o_rx_data;
	logic o_rx_tag;
	logic o_rx_valid;
	logic o_block_lock;
	lock_state_e o_lock_state;

	string case_op[$];
	int case_blocks[$];
	int case_header[$];
	int case_lock[$];

	// line bit history of both models with the newest bit at 0
	logic [`PCS_NB_SCRAMBLER-1:0] tx_history;
	logic [`PCS_NB_SCRAMBLER-1:0] rx_history;

	logic [`PCS_NB_CODED-1:0] rx_expected[$];
	logic rx_tag_expected[$];
	logic [`PCS_NB_TAGGED-1:0] tx_expected;
	logic tx_pending;

	int error_count;
	int check_count;
	int cycle_count;
	int cycle_limit;
	logic limit_ready;

	pcs_scrambler_loop uut (.*);

	initial
	begin
		i_clock = 1'b0;
		forever
			#20 i_clock = ~i_clock;
	end

	initial
	begin
		cycle_count = 0;
		wait (limit_ready);
		forever
		begin
			@(posedge i_clock);
			cycle_count++;
			if (cycle_count > cycle_limit)
			begin
				$display("Timeout after %0d cycles, the cases did not finish", cycle_count);
				$display("STATUS: FAIL");
				$finish;
			end
		end
	end

	task automatic compare_value(input string name, input logic [`PCS_NB_TAGGED-1:0] expected,
		input logic [`PCS_NB_TAGGED-1:0] actual);
		check_count++;
		assert (actual === expected)
		else
		begin
			$display("Mismatch at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
			error_count++;
		end
	endtask

	// x^58 + x^39 + 1 model where output bits feed the history
	task automatic scramble_model(input logic [NB_PAYLOAD-1:0] plain,
		output logic [NB_PAYLOAD-1:0] scrambled);
		logic bit_out;
		for (int i = NB_PAYLOAD - 1; i >= 0; i--)
		begin
			bit_out = plain[i] ^ tx_history[TAP_AGE-1] ^ tx_history[`PCS_NB_SCRAMBLER-1];
			scrambled[i] = bit_out;
			tx_history = {tx_history[`PCS_NB_SCRAMBLER-2:0], bit_out};
		end
	endtask

	// receive side model fed by the received bits
	task automatic descramble_model(input logic [NB_PAYLOAD-1:0] received,
		output logic [NB_PAYLOAD-1:0] recovered);
		for (int i = NB_PAYLOAD - 1; i >= 0; i--)
		begin
			recovered[i] = received[i] ^ rx_history[TAP_AGE-1] ^ rx_history[`PCS_NB_SCRAMBLER-1];
			rx_history = {rx_history[`PCS_NB_SCRAMBLER-2:0], received[i]};
		end
	endtask

	// choice 4 picks data or control at random
	function automatic logic [`PCS_NB_SH-1:0] pick_header(input int choice);
		logic [`PCS_NB_SH-1:0] header;
		if (choice == 4)
			header = ($urandom() % 2) ? SH_DATA : SH_CTRL;
		else
			header = choice[1:0];
		return header;
	endfunction

	task automatic read_cases(output logic ok);
		int fd;
		int fields;
		int blocks;
		int header;
		int lock;
		string line;
		string op;
		ok = 1'b0;
		fd = $fopen("verification/pcs_loop_cases.txt", "r");
		if (fd != 0)
		begin
			while ($fgets(line, fd) > 0)
			begin
				// comment lines never give four fields
				fields = $sscanf(line, "%s %d %d %d", op, blocks, header, lock);
				if (fields == 4)
				begin
					case_op.push_back(op);
					case_blocks.push_back(blocks);
					case_header.push_back(header);
					case_lock.push_back(lock);
				end
			end
			$fclose(fd);
			ok = (case_op.size() > 0);
		end
	endtask

	task automatic run_case(input int index);
		string op;
		int errors_before;
		logic [`PCS_NB_SH-1:0] header;
		logic [NB_PAYLOAD-1:0] payload;
		logic [NB_PAYLOAD-1:0] scrambled;
		logic [NB_PAYLOAD-1:0] recovered;
		logic [`PCS_NB_CODED-1:0] tx_block;
		logic [`PCS_NB_TAGGED-1:0] held_tx;
		logic [`PCS_NB_CODED-1:0] held_rx;
		logic stall;
		logic tag;
		logic bypass;
		logic idle;
		op = case_op[index];
		errors_before = error_count;
		stall = (op == "STALL");
		tag = (op == "TAG");
		bypass = (op == "BYPASS");
		idle = (op == "IDLE");
		held_tx = o_tx_data;
		held_rx = o_rx_data;
		for (int k = 0; k < case_blocks[index]; k++)
		begin
			@(negedge i_clock);
			if (tx_pending)
				compare_value("o_tx_data", tx_expected, o_tx_data);
			if (stall)
			begin
				compare_value("o_rx_valid", 1'b0, o_rx_valid);
				compare_value("o_tx_data", held_tx, o_tx_data);
				compare_value("o_rx_data", held_rx, o_rx_data);
			end
			header = pick_header(case_header[index]);
			payload = {$urandom(), $urandom()};
			i_enable = !stall;
			i_valid = 1'b1;
			i_bypass = bypass;
			i_aligner_tag = tag;
			i_idle_pattern_mode = idle;
			i_data = {header, payload};
			tx_pending = !stall;
			if (!stall)
			begin
				if (bypass || tag)
					tx_block = {header, payload};
				else
				begin
					scramble_model(idle ? IDLE_BLOCK[NB_PAYLOAD-1:0] : payload, scrambled);
					tx_block = {header, scrambled};
				end
				tx_expected = {tag, tx_block};
				if (tag)
					rx_expected.push_back(tx_block);
				else
				begin
					descramble_model(tx_block[NB_PAYLOAD-1:0], recovered);
					rx_expected.push_back({header, recovered});
				end
				rx_tag_expected.push_back(tag);
			end
		end
		@(negedge i_clock);
		if (tx_pending)
			compare_value("o_tx_data", tx_expected, o_tx_data);
		tx_pending = 1'b0;
		i_enable = 1'b1;
		i_valid = 1'b0;
		i_bypass = 1'b0;
		i_aligner_tag = 1'b0;
		i_idle_pattern_mode = 1'b0;
		// last block leaves the descrambler and then reaches the lock monitor
		repeat (2) @(negedge i_clock);
		compare_value("o_block_lock", case_lock[index], o_block_lock);
		compare_value("o_lock_state", (case_lock[index] != 0) ? LOCK_GOOD : LOCK_SEARCH,
			o_lock_state);
		assert (rx_expected.size() == 0)
		else
		begin
			$display("%0d blocks never came out of the receive path", rx_expected.size());
			error_count++;
		end
		if (error_count == errors_before)
			$display("case %0d %s, %0d blocks: ok", index, op, case_blocks[index]);
		else
			$display("case %0d %s, %0d blocks: %0d errors", index, op, case_blocks[index],
				error_count - errors_before);
	endtask

	// receive side checker with one expected entry per block
	always @(negedge i_clock)
	begin
		if (!i_reset && o_rx_valid)
		begin
			assert (rx_expected.size() > 0)
			else
			begin
				$display("Extra block at %0d ns, o_rx_valid high with nothing in flight", $time);
				error_count++;
			end
			if (rx_expected.size() > 0)
			begin
				compare_value("o_rx_data", rx_expected.pop_front(), o_rx_data);
				compare_value("o_rx_tag", rx_tag_expected.pop_front(), o_rx_tag);
			end
		end
	end

	initial
	begin
		logic file_ok;
		int total_blocks;
		i_reset = 1'b1;
		i_enable = 1'b0;
		i_valid = 1'b0;
		i_bypass = 1'b0;
		i_aligner_tag = 1'b0;
		i_idle_pattern_mode = 1'b0;
		i_data = '0;
		tx_history = '0;
		rx_history = '0;
		tx_pending = 1'b0;
		error_count = 0;
		check_count = 0;
		limit_ready = 1'b0;
		void'($urandom(26));
		read_cases(file_ok);
		if (!file_ok)
		begin
			$display("The case file could not be opened or holds no cases");
			$display("STATUS: FAIL");
			$finish;
		end
		else
		begin
			total_blocks = 0;
			foreach (case_blocks[i])
				total_blocks += case_blocks[i];
			cycle_limit = total_blocks + RESET_CYCLES + MARGIN_CYCLES;
			limit_ready = 1'b1;
			repeat (RESET_CYCLES) @(posedge i_clock);
			@(negedge i_clock);
			i_reset = 1'b0;
			i_enable = 1'b1;
			compare_value("o_tx_data", '0, o_tx_data);
			compare_value("o_rx_data", '0, o_rx_data);
			compare_value("o_rx_valid", 1'b0, o_rx_valid);
			compare_value("o_block_lock", 1'b0, o_block_lock);
			compare_value("o_lock_state", LOCK_INIT, o_lock_state);
			$display("reset values: %0d errors", error_count);
			for (int i = 0; i < case_op.size(); i++)
				run_case(i);
			$display("%0d cases, %0d checks, %0d errors", case_op.size(), check_count,
				error_count);
			if (error_count == 0)
				$display("STATUS: PASS");
			else
				$display("STATUS: FAIL");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: verilog/pcs_scrambler_loop.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcs_cfg.svh"

module pcs_scrambler_loop
(
	input logic i_clock,
	input logic i_reset,
	input logic i_enable,
	input logic i_valid,
	input logic i_bypass,
	input logic i_aligner_tag,
	input logic i_idle_pattern_mode,
	input logic [`PCS_NB_CODED-1:0] i_data,
	output logic [`PCS_NB_TAGGED-1:0] o_tx_data,
	output logic [`PCS_NB_CODED-1:0] o_rx_data,
	output logic o_rx_tag,
	output logic o_rx_valid,
	output logic o_block_lock,
	output pcs_pkg::lock_state_e o_lock_state
);

	logic scrambler_bypass;
	logic tx_valid;

	// tagged blocks must cross the line unscrambled
	assign scrambler_bypass = i_bypass | i_aligner_tag;

	pcs_scrambler u_scrambler
	(
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_enable(i_enable),
		.i_valid(i_valid),
		.i_bypass(scrambler_bypass),
		.i_aligner_tag(i_aligner_tag),
		.i_idle_pattern_mode(i_idle_pattern_mode),
		.i_data(i_data),
		.o_data(o_tx_data),
		.o_valid(tx_valid)
	);

	// loopback into the receive side
	pcs_descrambler u_descrambler
	(
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_data(o_tx_data),
		.i_valid(tx_valid),
		.o_data(o_rx_data),
		.o_tag(o_rx_tag),
		.o_valid(o_rx_valid)
	);

	pcs_block_lock u_block_lock
	(
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_valid(o_rx_valid),
		.i_sync_header(o_rx_data[`PCS_NB_CODED-1 -: `PCS_NB_SH]),
		.o_block_lock(o_block_lock),
		.o_lock_state(o_lock_state)
	);

endmodule

`default_nettype wire

// File: verilog/pcs_block_lock.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcs_cfg.svh"

module pcs_block_lock
(
	input logic i_clock,
	input logic i_reset,
	input logic i_valid,
	input logic [`PCS_NB_SH-1:0] i_sync_header,
	output logic o_block_lock,
	output pcs_pkg::lock_state_e o_lock_state
);

	import pcs_pkg::*;

	localparam int NB_GOOD = $clog2(`PCS_LOCK_GOOD);
	localparam int NB_WINDOW = $clog2(`PCS_LOCK_WINDOW);
	localparam int NB_BAD = $clog2(`PCS_LOCK_BAD);

	logic [NB_GOOD-1:0] good_count;
	logic [NB_WINDOW-1:0] window_count;
	logic [NB_BAD-1:0] bad_count;
	logic sh_ok;

	assign sh_ok = (i_sync_header == SH_DATA) || (i_sync_header == SH_CTRL);

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			o_lock_state <= LOCK_INIT;
			o_block_lock <= 1'b0;
			good_count <= '0;
			window_count <= '0;
			bad_count <= '0;
		end
		else if (i_valid)
		begin
			case (o_lock_state)
				LOCK_INIT:
				begin
					// first block already counts toward lock
					o_lock_state <= LOCK_SEARCH;
					good_count <= sh_ok ? NB_GOOD'(1) : '0;
				end
				LOCK_SEARCH:
				begin
					if (!sh_ok)
						good_count <= '0;
					else if (good_count == NB_GOOD'(`PCS_LOCK_GOOD - 1))
					begin
						o_lock_state <= LOCK_GOOD;
						o_block_lock <= 1'b1;
						good_count <= '0;
						window_count <= '0;
						bad_count <= '0;
					end
					else
						good_count <= good_count + 1'b1;
				end
				LOCK_GOOD:
				begin
					if (!sh_ok && bad_count == NB_BAD'(`PCS_LOCK_BAD - 1))
					begin
						o_lock_state <= LOCK_SEARCH;
						o_block_lock <= 1'b0;
						good_count <= '0;
					end
					else if (window_count == NB_WINDOW'(`PCS_LOCK_WINDOW - 1))
					begin
						// window closed so counting starts afresh
						window_count <= '0;
						bad_count <= '0;
					end
					else
					begin
						window_count <= window_count + 1'b1;
						bad_count <= bad_count + NB_BAD'(!sh_ok);
					end
				end
				default:
				begin
					o_lock_state <= LOCK_INIT;
					o_block_lock <= 1'b0;
				end
			endcase
		end
	end

	a_lock_matches_state: assert property (
		@(posedge i_clock) disable iff (i_reset)
		o_block_lock == (o_lock_state == LOCK_GOOD)
	);

	// lock always goes through a search phase
	a_no_init_to_good: assert property (
		@(posedge i_clock) disable iff (i_reset)
		(o_lock_state == LOCK_INIT) |=> (o_lock_state != LOCK_GOOD)
	);

endmodule

`default_nettype wire

// File: verilog/pcs_descrambler.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcs_cfg.svh"

module pcs_descrambler
#(
	parameter logic [`PCS_NB_SCRAMBLER-1:0] SEED = `PCS_SEED
)
(
	input logic i_clock,
	input logic i_reset,
	input logic [`PCS_NB_TAGGED-1:0] i_data,
	input logic i_valid,
	output logic [`PCS_NB_CODED-1:0] o_data,
	output logic o_tag,
	output logic o_valid
);

	localparam int NB_PAYLOAD = `PCS_NB_CODED - `PCS_NB_SH;

	logic [`PCS_NB_SCRAMBLER-1:0] descrambler_state;
	logic [`PCS_NB_SCRAMBLER-1:0] state_next;
	logic [NB_PAYLOAD-1:0] payload_in;
	logic [NB_PAYLOAD-1:0] descrambled_payload;
	logic tag_in;

	assign tag_in = i_data[`PCS_NB_TAGGED-1];
	assign payload_in = i_data[NB_PAYLOAD-1:0];

	// received line bits feed the state, so a wrong seed washes out in one block
	always_comb
	begin
		state_next = descrambler_state;
		for (int i = NB_PAYLOAD - 1; i >= 0; i--)
		begin
			descrambled_payload[i] = payload_in[i] ^ state_next[0] ^ state_next[`PCS_TAP];
			state_next = {payload_in[i], state_next[`PCS_NB_SCRAMBLER-1:1]};
		end
	end

	// tagged blocks were never scrambled, state holds
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			descrambler_state <= SEED;
		else if (i_valid && !tag_in)
			descrambler_state <= state_next;
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			o_data <= '0;
			o_tag <= 1'b0;
		end
		else if (i_valid)
		begin
			o_tag <= tag_in;
			if (tag_in)
				o_data <= i_data[`PCS_NB_CODED-1:0];
			else
				o_data <= {i_data[`PCS_NB_CODED-1 -: `PCS_NB_SH], descrambled_payload};
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			o_valid <= 1'b0;
		else
			o_valid <= i_valid;
	end

	a_no_valid_after_reset: assert property (
		@(posedge i_clock) i_reset |=> !o_valid
	);

endmodule

`default_nettype wire

// File: verilog/pcs_scrambler.sv
`timescale 1ns/1ps
`default_nettype none

`include "pcs_cfg.svh"

module pcs_scrambler
#(
	parameter logic [`PCS_NB_SCRAMBLER-1:0] SEED = `PCS_SEED
)
(
	input logic i_clock,
	input logic i_reset,
	input logic i_enable,
	input logic i_valid,
	input logic i_bypass,
	input logic i_aligner_tag,
	input logic i_idle_pattern_mode,
	input logic [`PCS_NB_CODED-1:0] i_data,
	output logic [`PCS_NB_TAGGED-1:0] o_data,
	output logic o_valid
);

	import pcs_pkg::*;

	localparam int NB_PAYLOAD = `PCS_NB_CODED - `PCS_NB_SH;

	logic [`PCS_NB_SCRAMBLER-1:0] scrambler_state;
	logic [`PCS_NB_SCRAMBLER-1:0] state_next;
	logic [NB_PAYLOAD-1:0] payload_in;
	logic [NB_PAYLOAD-1:0] scrambled_payload;
	logic [`PCS_NB_SH-1:0] sync_header;
	logic accept;

	assign accept = i_enable && i_valid;
	assign sync_header = i_data[`PCS_NB_CODED-1 -: `PCS_NB_SH];

	// bit-serial scrambler unrolled over the payload, msb first
	always_comb
	begin
		state_next = scrambler_state;
		if (i_idle_pattern_mode)
			payload_in = IDLE_BLOCK[NB_PAYLOAD-1:0];
		else
			payload_in = i_data[NB_PAYLOAD-1:0];
		for (int i = NB_PAYLOAD - 1; i >= 0; i--)
		begin
			scrambled_payload[i] = payload_in[i] ^ state_next[0] ^ state_next[`PCS_TAP];
			// newest output bit enters at the top
			state_next = {scrambled_payload[i], state_next[`PCS_NB_SCRAMBLER-1:1]};
		end
	end

	// state only moves on scrambled blocks
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			scrambler_state <= SEED;
		else if (accept && !i_bypass)
			scrambler_state <= state_next;
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			o_data <= '0;
		end
		else if (accept)
		begin
			o_data[`PCS_NB_TAGGED-1] <= i_aligner_tag;
			if (i_bypass)
				o_data[`PCS_NB_CODED-1:0] <= i_data;
			else
				o_data[`PCS_NB_CODED-1:0] <= {sync_header, scrambled_payload};
		end
	end

	// one registered valid level per accepted block
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			o_valid <= 1'b0;
		else
			o_valid <= accept;
	end

	// bypassed block reaches the output untouched, tag included
	a_bypass_passthrough: assert property (
		@(posedge i_clock) disable iff (i_reset)
		(i_enable && i_valid && i_bypass) |=>
			(o_data == {$past(i_aligner_tag), $past(i_data)})
	);

endmodule

`default_nettype wire

// File: verilog/pcs_pkg.sv
`default_nettype none

`include "pcs_cfg.svh"

package pcs_pkg;

	// 2-bit sync header, 00 and 11 are invalid
	typedef enum logic [`PCS_NB_SH-1:0]
	{
		SH_DATA = 2'b01,
		SH_CTRL = 2'b10
	} sync_header_e;

	typedef enum logic [1:0]
	{
		LOCK_INIT,
		LOCK_SEARCH,
		LOCK_GOOD
	} lock_state_e;

	// control header, block type 0x1e, eight idle characters
	localparam logic [`PCS_NB_CODED-1:0] IDLE_BLOCK = 66'h2_1E00_0000_0000_0000;

endpackage

`default_nettype wire

// File: verilog/pcs_cfg.svh
`ifndef PCS_CFG_SVH
`define PCS_CFG_SVH

// block widths
`define PCS_NB_CODED 66
`define PCS_NB_TAGGED 67
`define PCS_NB_SH 2

// x^58 + x^39 + 1 scrambler
`define PCS_NB_SCRAMBLER 58
// x^39 tap, counted from the oldest bit of the state
`define PCS_TAP 19
`define PCS_SEED 0

// lock acquisition, consecutive good headers
`define PCS_LOCK_GOOD 64

// lock loss, bad headers inside one window
`define PCS_LOCK_WINDOW 64
`define PCS_LOCK_BAD 16

`endif
